/* design/tw_bridge_pkg.sv */
`default_nettype none

package tw_bridge_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // One byte on the host link
    typedef logic [7:0] host_byte_t;

    // Three-wire register address and data word
    typedef logic [8:0]  tw_addr_t;
    typedef logic [15:0] tw_data_t;

    // Host bytes per address and per data word, MSB first
    localparam int ADDR_BYTES = 2;
    localparam int DATA_BYTES = 2;

    // Host command bytes
    typedef enum host_byte_t {
        CMD_READ  = 8'h00,
        CMD_WRITE = 8'h01,
        CMD_OK    = 8'h02,
        CMD_PING  = 8'hFF
    } host_cmd_e;

    // One three-wire transaction, laid out in frame order
    typedef struct packed {
        logic     write;
        tw_addr_t addr;
        tw_data_t wr_data;
    } tw_request_t;

    ////////////////////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        LINK_RX_READY,
        LINK_RX_RECEIVED,
        LINK_DECODING,
        LINK_TX_READY,
        LINK_TX_REQUEST,
        LINK_TX_ACKED
    } link_state_e;

    typedef enum logic [2:0] {
        DEC_WAIT_CMD,
        DEC_WAIT_ADDR,
        DEC_WAIT_WRDATA,
        DEC_TW_STARTED,
        DEC_WAIT_TW_COMPLETE,
        DEC_TX_ANSWER
    } decoder_state_e;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SHIFT,
        SER_FINISH
    } serial_state_e;

endpackage

`default_nettype wire

/* design/host_byte_link.sv */
`default_nettype none

module host_byte_link
(
    input  logic in_clk,
    input  logic in_rst,
    input  logic rx_req,
    output logic rx_ack,
    output logic tx_req,
    input  logic tx_ack,
    output logic rx_enable,
    input  logic rx_trig,
    input  logic tx_trig,
    output logic rx_done,
    output logic tx_done
);

    tw_bridge_pkg::link_state_e state;
    tw_bridge_pkg::link_state_e next_state;

    // Trigs that arrive while the host still holds tx_ack
    logic rx_pend;
    logic tx_pend;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            tw_bridge_pkg::LINK_RX_READY:
            begin
                if (rx_req)
                    next_state = tw_bridge_pkg::LINK_RX_RECEIVED;
            end
            tw_bridge_pkg::LINK_RX_RECEIVED:
            begin
                if (!rx_req)
                    next_state = tw_bridge_pkg::LINK_DECODING;
            end
            tw_bridge_pkg::LINK_DECODING:
            begin
                if (rx_trig)
                    next_state = tw_bridge_pkg::LINK_RX_READY;
                else if (tx_trig)
                    next_state = tw_bridge_pkg::LINK_TX_READY;
            end
            tw_bridge_pkg::LINK_TX_READY:
                next_state = tw_bridge_pkg::LINK_TX_REQUEST;
            tw_bridge_pkg::LINK_TX_REQUEST:
            begin
                if (tx_ack)
                    next_state = tw_bridge_pkg::LINK_TX_ACKED;
            end
            tw_bridge_pkg::LINK_TX_ACKED:
            begin
                // Host must release tx_ack before the next byte
                if (!tx_ack && (tx_trig || tx_pend))
                    next_state = tw_bridge_pkg::LINK_TX_READY;
                else if (!tx_ack && (rx_trig || rx_pend))
                    next_state = tw_bridge_pkg::LINK_RX_READY;
            end
            default:
                next_state = tw_bridge_pkg::LINK_RX_READY;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // State register and done pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            state   <= tw_bridge_pkg::LINK_RX_READY;
            rx_done <= 1'b0;
            tx_done <= 1'b0;
            rx_pend <= 1'b0;
            tx_pend <= 1'b0;
        end
        else
        begin
            state   <= next_state;
            rx_done <= (state == tw_bridge_pkg::LINK_RX_RECEIVED) && !rx_req;
            tx_done <= (state == tw_bridge_pkg::LINK_TX_REQUEST) && tx_ack;

            if (next_state != tw_bridge_pkg::LINK_TX_ACKED)
            begin
                rx_pend <= 1'b0;
                tx_pend <= 1'b0;
            end
            else
            begin
                rx_pend <= rx_pend || rx_trig;
                tx_pend <= tx_pend || tx_trig;
            end
        end
    end

    // Host levels straight from the state
    assign rx_enable = (state == tw_bridge_pkg::LINK_RX_READY);
    assign rx_ack    = (state == tw_bridge_pkg::LINK_RX_RECEIVED);
    assign tx_req    = (state == tw_bridge_pkg::LINK_TX_REQUEST);

endmodule

`default_nettype wire

/* design/tw_command_decoder.sv */
`default_nettype none

module tw_command_decoder
(
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  tw_bridge_pkg::host_byte_t data_rx,
    input  logic                      rx_done,
    input  logic                      tx_done,
    output logic                      rx_trig,
    output logic                      tx_trig,
    output tw_bridge_pkg::host_byte_t data_tx,
    output tw_bridge_pkg::tw_request_t request,
    output logic                      start,
    input  logic                      busy,
    input  tw_bridge_pkg::tw_data_t   rd_data
);

    tw_bridge_pkg::decoder_state_e state;

    // Bytes still expected (rx) or still to send (tx) after the current one
    logic [1:0] byte_cnt;
    logic       is_write;

    tw_bridge_pkg::tw_addr_t addr_q;
    tw_bridge_pkg::tw_data_t wr_data_q;

    assign request = '{write: is_write, addr: addr_q, wr_data: wr_data_q};

    ////////////////////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            state    <= tw_bridge_pkg::DEC_WAIT_CMD;
            byte_cnt <= '0;
            is_write <= 1'b0;
            rx_trig  <= 1'b0;
            tx_trig  <= 1'b0;
            start    <= 1'b0;
        end
        else
        begin
            // Trigs and start are single-cycle pulses
            rx_trig <= 1'b0;
            tx_trig <= 1'b0;
            start   <= 1'b0;

            case (state)
                tw_bridge_pkg::DEC_WAIT_CMD:
                begin
                    if (rx_done)
                    begin
                        if (data_rx == tw_bridge_pkg::CMD_READ ||
                            data_rx == tw_bridge_pkg::CMD_WRITE)
                        begin
                            is_write <= (data_rx == tw_bridge_pkg::CMD_WRITE);
                            byte_cnt <= 2'(tw_bridge_pkg::ADDR_BYTES - 1);
                            rx_trig  <= 1'b1;
                            state    <= tw_bridge_pkg::DEC_WAIT_ADDR;
                        end
                        else if (data_rx == tw_bridge_pkg::CMD_PING)
                        begin
                            byte_cnt <= '0;
                            tx_trig  <= 1'b1;
                            state    <= tw_bridge_pkg::DEC_TX_ANSWER;
                        end
                        else
                            rx_trig <= 1'b1; // unknown, drop it
                    end
                end

                tw_bridge_pkg::DEC_WAIT_ADDR:
                begin
                    if (rx_done)
                    begin
                        if (byte_cnt != 0)
                        begin
                            byte_cnt <= byte_cnt - 2'd1;
                            rx_trig  <= 1'b1;
                        end
                        else if (is_write)
                        begin
                            byte_cnt <= 2'(tw_bridge_pkg::DATA_BYTES - 1);
                            rx_trig  <= 1'b1;
                            state    <= tw_bridge_pkg::DEC_WAIT_WRDATA;
                        end
                        else
                        begin
                            start <= 1'b1;
                            state <= tw_bridge_pkg::DEC_TW_STARTED;
                        end
                    end
                end

                tw_bridge_pkg::DEC_WAIT_WRDATA:
                begin
                    if (rx_done)
                    begin
                        if (byte_cnt != 0)
                        begin
                            byte_cnt <= byte_cnt - 2'd1;
                            rx_trig  <= 1'b1;
                        end
                        else
                        begin
                            start <= 1'b1;
                            state <= tw_bridge_pkg::DEC_TW_STARTED;
                        end
                    end
                end

                tw_bridge_pkg::DEC_TW_STARTED:
                begin
                    if (busy)
                        state <= tw_bridge_pkg::DEC_WAIT_TW_COMPLETE;
                end

                tw_bridge_pkg::DEC_WAIT_TW_COMPLETE:
                begin
                    if (!busy)
                    begin
                        // Write answers OK, read answers the whole word
                        byte_cnt <= is_write ? 2'd0 : 2'(tw_bridge_pkg::DATA_BYTES - 1);
                        tx_trig  <= 1'b1;
                        state    <= tw_bridge_pkg::DEC_TX_ANSWER;
                    end
                end

                tw_bridge_pkg::DEC_TX_ANSWER:
                begin
                    if (tx_done)
                    begin
                        if (byte_cnt != 0)
                        begin
                            byte_cnt <= byte_cnt - 2'd1;
                            tx_trig  <= 1'b1;
                        end
                        else
                        begin
                            rx_trig <= 1'b1;
                            state   <= tw_bridge_pkg::DEC_WAIT_CMD;
                        end
                    end
                end

                default:
                    state <= tw_bridge_pkg::DEC_WAIT_CMD;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address, write data and reply byte
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge in_clk)
    begin
        if (state == tw_bridge_pkg::DEC_WAIT_CMD && rx_done)
            data_tx <= tw_bridge_pkg::CMD_OK;

        // Only the low 9 address bits survive the shift
        if (state == tw_bridge_pkg::DEC_WAIT_ADDR && rx_done)
            addr_q <= {addr_q[0], data_rx};

        if (state == tw_bridge_pkg::DEC_WAIT_WRDATA && rx_done)
            wr_data_q <= {wr_data_q[7:0], data_rx};

        if (state == tw_bridge_pkg::DEC_WAIT_TW_COMPLETE && !busy)
        begin
            if (is_write)
                data_tx <= tw_bridge_pkg::CMD_OK;
            else
                data_tx <= rd_data[(tw_bridge_pkg::DATA_BYTES - 1) * 8 +: 8];
        end

        // Next lower read byte
        if (state == tw_bridge_pkg::DEC_TX_ANSWER && tx_done && byte_cnt != 0)
            data_tx <= rd_data[(byte_cnt - 1) * 8 +: 8];
    end

endmodule

`default_nettype wire

/* design/tw_serial_master.sv */
`default_nettype none

module tw_serial_master
#(
    parameter int tw_half_period = 4
)
(
    input  logic                       in_clk,
    input  logic                       in_rst,
    input  tw_bridge_pkg::tw_request_t request,
    input  logic                       start,
    output logic                       busy,
    output tw_bridge_pkg::tw_data_t    rd_data,
    output logic                       tw_clock,
    output logic                       tw_cs,
    inout  wire                        tw_data
);

    localparam int FRAME_BITS = $bits(tw_bridge_pkg::tw_request_t);
    localparam int DATA_BITS  = $bits(tw_bridge_pkg::tw_data_t);
    // rw bit plus address bits come first
    localparam int HEAD_BITS  = FRAME_BITS - DATA_BITS;
    localparam int DIV_W      = (tw_half_period > 1) ? $clog2(tw_half_period) : 1;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(tw_half_period - 1);
    localparam logic [4:0]       BIT_LAST = 5'(FRAME_BITS - 1);
    localparam logic [4:0]       HEAD_END = 5'(HEAD_BITS);

    tw_bridge_pkg::serial_state_e state;

    logic [DIV_W-1:0]      div_cnt;
    logic [4:0]            bit_cnt;
    logic                  frame_write;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  rx_bit;
    logic                  half_tick;
    logic                  drive_en;

    assign half_tick = (div_cnt == DIV_LAST);

    // Master owns the line for the header, and for data only on writes
    assign drive_en = (state != tw_bridge_pkg::SER_IDLE) &&
                      ((bit_cnt < HEAD_END) || frame_write);
    assign tw_data  = drive_en ? shift_reg[FRAME_BITS-1] : 1'bz;

    ////////////////////////////////////////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            state       <= tw_bridge_pkg::SER_IDLE;
            busy        <= 1'b0;
            tw_cs       <= 1'b1;
            tw_clock    <= 1'b0;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            frame_write <= 1'b0;
        end
        else
        begin
            div_cnt <= (state == tw_bridge_pkg::SER_IDLE || half_tick) ? '0 : div_cnt + 1'b1;
            case (state)
                tw_bridge_pkg::SER_IDLE:
                begin
                    if (start)
                    begin
                        frame_write <= request.write;
                        bit_cnt     <= '0;
                        busy        <= 1'b1;
                        tw_cs       <= 1'b0;
                        state       <= tw_bridge_pkg::SER_SHIFT;
                    end
                end
                tw_bridge_pkg::SER_SHIFT:
                begin
                    if (half_tick)
                    begin
                        tw_clock <= !tw_clock;
                        // Last rising edge ends the shift phase
                        if (!tw_clock && bit_cnt == BIT_LAST)
                            state <= tw_bridge_pkg::SER_FINISH;
                        if (tw_clock)
                            bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                tw_bridge_pkg::SER_FINISH:
                begin
                    if (half_tick)
                    begin
                        tw_clock <= 1'b0;
                        tw_cs    <= 1'b1;
                        busy     <= 1'b0;
                        state    <= tw_bridge_pkg::SER_IDLE;
                    end
                end
                default:
                    state <= tw_bridge_pkg::SER_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift register and read capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge in_clk)
    begin
        if (state == tw_bridge_pkg::SER_IDLE && start)
            shift_reg <= request;

        if (state == tw_bridge_pkg::SER_SHIFT && half_tick)
        begin
            // Sample on rising, shift on falling
            if (!tw_clock)
                rx_bit <= tw_data;
            else
                shift_reg <= {shift_reg[FRAME_BITS-2:0], rx_bit};
        end

        // Last sampled bit never reaches the shift register
        if (state == tw_bridge_pkg::SER_FINISH && half_tick)
            rd_data <= {shift_reg[DATA_BITS-2:0], rx_bit};
    end

endmodule

`default_nettype wire

/* design/tw_bridge_top.sv */
`default_nettype none

module tw_bridge_top
#(
    parameter int tw_half_period = 4
)
(
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  tw_bridge_pkg::host_byte_t data_rx,
    input  logic                      rx_req,
    output logic                      rx_ack,
    output tw_bridge_pkg::host_byte_t data_tx,
    output logic                      tx_req,
    input  logic                      tx_ack,
    output logic                      rx_enable,
    output logic                      tw_clock,
    output logic                      tw_cs,
    inout  wire                       tw_data
);

    // Link and decoder handshake
    logic rx_done;
    logic tx_done;
    logic rx_trig;
    logic tx_trig;

    // Decoder and serial master
    tw_bridge_pkg::tw_request_t request;
    tw_bridge_pkg::tw_data_t    rd_data;
    logic                       start;
    logic                       busy;

    host_byte_link u_link
    (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .rx_req    (rx_req),
        .rx_ack    (rx_ack),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .rx_enable (rx_enable),
        .rx_trig   (rx_trig),
        .tx_trig   (tx_trig),
        .rx_done   (rx_done),
        .tx_done   (tx_done)
    );

    // Received byte goes straight to the decoder
    tw_command_decoder u_decoder
    (
        .in_clk  (in_clk),
        .in_rst  (in_rst),
        .data_rx (data_rx),
        .rx_done (rx_done),
        .tx_done (tx_done),
        .rx_trig (rx_trig),
        .tx_trig (tx_trig),
        .data_tx (data_tx),
        .request (request),
        .start   (start),
        .busy    (busy),
        .rd_data (rd_data)
    );

    tw_serial_master #(
        .tw_half_period (tw_half_period)
    ) u_master (
        .in_clk   (in_clk),
        .in_rst   (in_rst),
        .request  (request),
        .start    (start),
        .busy     (busy),
        .rd_data  (rd_data),
        .tw_clock (tw_clock),
        .tw_cs    (tw_cs),
        .tw_data  (tw_data)
    );

endmodule

`default_nettype wire

/* bench/tw_slave_model.sv */
`default_nettype none

module tw_slave_model
(
    input wire tw_clock,
    input wire tw_cs,
    inout wire tw_data
);

    localparam int FRAME_BITS = 26;
    localparam int HEAD_BITS  = 10;

    logic [15:0] mem [512];
    logic [25:0] frame_in;
    logic [15:0] read_word;
    int          bit_idx;
    logic        read_frame;
    logic        drive_en;
    logic        drive_bit;

    assign tw_data = drive_en ? drive_bit : 1'bz;

    initial
    begin
        // Fill word depends on all nine address bits
        for (int i = 0; i < 512; i++)
            mem[i] = 16'(i) ^ (16'(i) << 7) ^ 16'hC3A0;
        frame_in   = '0;
        read_word  = '0;
        bit_idx    = 0;
        read_frame = 1'b0;
        drive_en   = 1'b0;
        drive_bit  = 1'b0;
    end

    always @(negedge tw_cs)
    begin
        bit_idx    = 0;
        read_frame = 1'b0;
    end

    always @(posedge tw_cs)
        drive_en = 1'b0;

    // Frame is rw, address, data, all MSB first
    always @(posedge tw_clock)
    begin
        if (!tw_cs)
        begin
            frame_in = {frame_in[24:0], tw_data};
            bit_idx  = bit_idx + 1;
            if (bit_idx == FRAME_BITS && frame_in[25])
                mem[frame_in[24:16]] = frame_in[15:0];
        end
    end

    // Read bits go out while the clock is low
    always @(negedge tw_clock)
    begin
        if (!tw_cs && bit_idx == HEAD_BITS && !frame_in[9])
        begin
            read_frame = 1'b1;
            read_word  = mem[frame_in[8:0]];
        end
        if (!tw_cs && read_frame && bit_idx < FRAME_BITS)
        begin
            drive_en  = 1'b1;
            drive_bit = read_word[FRAME_BITS - 1 - bit_idx];
        end
        else
            drive_en = 1'b0;
    end

endmodule

`default_nettype wire

/* bench/tw_bridge_asserts.sv */
`default_nettype none

module tw_bridge_asserts
(
    input logic in_clk,
    input logic in_rst,
    input logic rx_ack,
    input logic tx_req,
    input logic rx_enable,
    input logic tw_clock,
    input logic tw_cs
);

    // Set once the first command byte is taken
    logic cmd_seen;

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
            cmd_seen <= 1'b0;
        else if (rx_ack)
            cmd_seen <= 1'b1;
    end

    tx_rx_exclusive: assert property (@(posedge in_clk) disable iff (in_rst)
        !(tx_req && rx_ack))
        else $error("tx_req and rx_ack are high together");

    enable_not_ack: assert property (@(posedge in_clk) disable iff (in_rst)
        !(rx_enable && rx_ack))
        else $error("rx_enable is high together with rx_ack");

    clock_idle: assert property (@(posedge in_clk) disable iff (in_rst)
        tw_cs |-> !tw_clock)
        else $error("tw_clock toggles while tw_cs is high");

    no_early_reply: assert property (@(posedge in_clk) disable iff (in_rst)
        !cmd_seen |-> !tx_req)
        else $error("tx_req rose before any command was received");

endmodule

bind tw_bridge_top tw_bridge_asserts u_asserts
(
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .rx_ack    (rx_ack),
    .tx_req    (tx_req),
    .rx_enable (rx_enable),
    .tw_clock  (tw_clock),
    .tw_cs     (tw_cs)
);

`default_nettype wire

/* bench/tw_bridge_tb.sv */
`default_nettype none

module tw_bridge_tb;

    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_TEST = 1500;

    // One line of the data file
    typedef struct packed {
        logic [8*24-1:0] name;
        logic [2:0]      cmd_len;
        logic [4:0][7:0] cmd;
        logic [1:0]      rsp_len;
        logic [1:0][7:0] rsp;
        logic            slow;
    } test_vec_t;

    logic                      in_clk;
    logic                      in_rst;
    tw_bridge_pkg::host_byte_t data_rx;
    logic                      rx_req;
    logic                      rx_ack;
    tw_bridge_pkg::host_byte_t data_tx;
    logic                      tx_req;
    logic                      tx_ack;
    logic                      rx_enable;
    logic                      tw_clock;
    logic                      tw_cs;
    wire                       tw_data;

    test_vec_t                 tests[$];
    tw_bridge_pkg::host_byte_t reply_q[$];
    int                        errors = 0;
    int                        tests_run = 0;
    int                        tests_failed = 0;
    int                        cycles = 0;
    int                        cycle_limit = 0;

    tw_bridge_top #(
        .tw_half_period (4)
    ) UUT (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .data_rx   (data_rx),
        .rx_req    (rx_req),
        .rx_ack    (rx_ack),
        .data_tx   (data_tx),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .rx_enable (rx_enable),
        .tw_clock  (tw_clock),
        .tw_cs     (tw_cs),
        .tw_data   (tw_data)
    );

    tw_slave_model u_slave
    (
        .tw_clock (tw_clock),
        .tw_cs    (tw_cs),
        .tw_data  (tw_data)
    );

    initial
    begin
        in_clk = 1'b0;
        forever
            #10 in_clk = ~in_clk;
    end

    always @(posedge in_clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering the host", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and host side
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string sig, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
            errors++;
        end
    endtask

    // Host reaction time of 0 to 7 cycles when slow
    task automatic ack_delay(input logic slow);
        int n;
        n = slow ? int'($urandom % 8) : 0;
        repeat (n)
            @(negedge in_clk);
    endtask

    task automatic send_byte(input tw_bridge_pkg::host_byte_t value, input logic slow);
        while (!rx_enable)
            @(negedge in_clk);
        data_rx = value;
        rx_req  = 1'b1;
        @(negedge in_clk);
        while (!rx_ack)
            @(negedge in_clk);
        ack_delay(slow);
        rx_req = 1'b0;
        @(negedge in_clk);
    endtask

    // Reply is over once the link waits for a new command
    task automatic collect_reply(input logic slow);
        reply_q.delete();
        while (!rx_enable)
        begin
            if (tx_req)
            begin
                reply_q.push_back(data_tx);
                ack_delay(slow);
                tx_ack = 1'b1;
                @(negedge in_clk);
                while (tx_req)
                    @(negedge in_clk);
                ack_delay(slow);
                tx_ack = 1'b0;
            end
            @(negedge in_clk);
        end
    endtask

    task automatic load_tests();
        int              fd;
        int              fields;
        string           line;
        logic [8*24-1:0] name;
        int              cmd_len;
        int              rsp_len;
        int              slow;
        int              b0;
        int              b1;
        int              b2;
        int              b3;
        int              b4;
        int              r0;
        int              r1;
        test_vec_t       t;

        fd = $fopen("bench/tw_bridge_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the test data file bench/tw_bridge_testdata.txt");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 0 && line[0] != "#")
                begin
                    fields = $sscanf(line, "%s %d %h %h %h %h %h %d %h %h %d", name,
                                     cmd_len, b0, b1, b2, b3, b4, rsp_len, r0, r1, slow);
                    if (fields == 11)
                    begin
                        t.name    = name;
                        t.cmd_len = 3'(cmd_len);
                        t.cmd     = {8'(b4), 8'(b3), 8'(b2), 8'(b1), 8'(b0)};
                        t.rsp_len = 2'(rsp_len);
                        t.rsp     = {8'(r1), 8'(r0)};
                        t.slow    = (slow != 0);
                        tests.push_back(t);
                    end
                end
            end
            $fclose(fd);
            if (tests.size() == 0)
            begin
                $display("The test data file holds no usable test line");
                errors++;
            end
        end
    endtask

    task automatic run_test(input test_vec_t t);
        int                      errors_before;
        int                      i;
        tw_bridge_pkg::tw_addr_t addr;
        tw_bridge_pkg::tw_data_t data;

        errors_before = errors;
        for (i = 0; i < int'(t.cmd_len); i++)
            send_byte(t.cmd[i], t.slow);
        collect_reply(t.slow);

        check_value("reply byte count", 16'(reply_q.size()), 16'(t.rsp_len));
        for (i = 0; i < int'(t.rsp_len) && i < reply_q.size(); i++)
            check_value($sformatf("data_tx byte %0d", i), 16'(reply_q[i]), 16'(t.rsp[i]));

        // A write must have landed in the slave at the low 9 address bits
        if (t.cmd_len == 3'd5 && t.cmd[0] == tw_bridge_pkg::CMD_WRITE)
        begin
            addr = 9'({t.cmd[1], t.cmd[2]});
            data = {t.cmd[3], t.cmd[4]};
            check_value($sformatf("slave mem[%03h]", addr), u_slave.mem[addr], data);
        end

        tests_run++;
        if (errors == errors_before)
            $display("Test %0s: ok", t.name);
        else
        begin
            tests_failed++;
            $display("Test %0s: FAILED", t.name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h4fca));
        in_rst  = 1'b1;
        data_rx = '0;
        rx_req  = 1'b0;
        tx_ack  = 1'b0;

        load_tests();
        cycle_limit = tests.size() * CYCLES_PER_TEST + RESET_CYCLES + 4;

        repeat (RESET_CYCLES)
            @(negedge in_clk);
        in_rst = 1'b0;
        @(negedge in_clk);

        // Idle levels right after reset
        check_value("rx_enable", 16'(rx_enable), 16'd1);
        check_value("tx_req", 16'(tx_req), 16'd0);
        check_value("rx_ack", 16'(rx_ack), 16'd0);
        check_value("tw_clock", 16'(tw_clock), 16'd0);
        check_value("tw_cs", 16'(tw_cs), 16'd1);
        tests_run++;
        if (errors == 0)
            $display("Test reset_state: ok");
        else
        begin
            tests_failed++;
            $display("Test reset_state: FAILED");
        end

        foreach (tests[k])
            run_test(tests[k]);

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tw_bridge_testdata.txt */
# name  cmd_len  cmd0 cmd1 cmd2 cmd3 cmd4 (hex)  rsp_len  rsp0 rsp1 (hex)  slow_ack
# unused byte columns hold 00
ping                1  ff 00 00 00 00  1  02 00  0
write_0a5           5  01 00 a5 12 34  1  02 00  0
read_0a5            3  00 00 a5 00 00  2  12 34  0
write_13c_slow      5  01 01 3c be ef  1  02 00  1
read_13c_slow       3  00 01 3c 00 00  2  be ef  1
read_0a5_slow       3  00 00 a5 00 00  2  12 34  1
unknown_55          1  55 00 00 00 00  0  00 00  0
ping_after_unknown  1  ff 00 00 00 00  1  02 00  0
unknown_02          1  02 00 00 00 00  0  00 00  1
ping_slow           1  ff 00 00 00 00  1  02 00  1
write_1a5           5  01 01 a5 c3 5a  1  02 00  0
read_3a5_alias      3  00 03 a5 00 00  2  c3 5a  1

/* verilog.f */
design/tw_bridge_pkg.sv
design/host_byte_link.sv
design/tw_command_decoder.sv
design/tw_serial_master.sv
design/tw_bridge_top.sv
bench/tw_slave_model.sv
bench/tw_bridge_asserts.sv
bench/tw_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tw_bridge_tb \
    -f verilog.f \
    -o tw_bridge_sim

./obj_dir/tw_bridge_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Result: pass"
else
    echo "Result: fail"
    exit 1
fi
